//--- common/jvm_core_pkg.sv
`default_nettype none

package jvm_core_pkg;

    typedef logic [31:0]        word_t;       // stack and local variable value
    typedef logic [7:0]         lva_index_t;
    typedef logic signed [15:0] pc_offset_t;  // distance from current instruction
    typedef logic [1:0]         arg_count_t;  // argument bytes after the opcode

    typedef struct packed {
        logic  push;      // low for a pop
        logic  trigger;
        word_t wdata;
    } stack_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;     // valid with done on a pop
    } stack_rsp_t;

    typedef struct packed {
        logic       write;
        logic       trigger;
        lva_index_t index;
        word_t      wdata;
    } lva_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } lva_rsp_t;

    typedef struct packed {
        logic                   is_const;
        logic                   is_lit;
        logic                   is_alu;
        logic                   is_cmp;       // compare with zero
        logic                   is_cmp2;      // compare two stack values
        logic                   is_goto;
        logic                   is_load;
        logic                   is_store;
        logic                   is_pop;
        logic                   is_dup;
        jvm_isa_pkg::alu_op_t   alu_op;
        jvm_isa_pkg::cmp_kind_t cmp_kind;
        word_t                  const_val;
        lva_index_t             short_index;  // index of the _0 to _3 forms
        logic                   has_index_arg;
        arg_count_t             arg_count;
        logic [1:0]             pops;
        logic [1:0]             pushes;
    } decoded_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_POP_LOAD,
        ST_LVA_START,
        ST_LVA_WAIT,
        ST_EXEC,
        ST_PUSH,
        ST_PUSH_WAIT
    } seq_state_t;

    localparam int FETCH_WAIT = 3;            // idle cycles before opcode sample

endpackage

`default_nettype wire

//--- common/jvm_isa_pkg.sv
`default_nettype none

package jvm_isa_pkg;

    typedef logic [7:0] opcode_t;     // one bytecode
    typedef logic [3:0] alu_op_t;
    typedef logic [2:0] cmp_kind_t;

    localparam opcode_t NOP       = 8'h00;
    localparam opcode_t ICONST_M1 = 8'h02;
    localparam opcode_t ICONST_0  = 8'h03;
    localparam opcode_t ICONST_1  = 8'h04;
    localparam opcode_t ICONST_2  = 8'h05;
    localparam opcode_t ICONST_3  = 8'h06;
    localparam opcode_t ICONST_4  = 8'h07;
    localparam opcode_t ICONST_5  = 8'h08;
    localparam opcode_t BIPUSH    = 8'h10;
    localparam opcode_t SIPUSH    = 8'h11;
    localparam opcode_t ILOAD     = 8'h15;
    localparam opcode_t ILOAD_0   = 8'h1a;
    localparam opcode_t ILOAD_1   = 8'h1b;
    localparam opcode_t ILOAD_2   = 8'h1c;
    localparam opcode_t ILOAD_3   = 8'h1d;
    localparam opcode_t ISTORE    = 8'h36;
    localparam opcode_t ISTORE_0  = 8'h3b;
    localparam opcode_t ISTORE_1  = 8'h3c;
    localparam opcode_t ISTORE_2  = 8'h3d;
    localparam opcode_t ISTORE_3  = 8'h3e;
    localparam opcode_t POP       = 8'h57;
    localparam opcode_t DUP       = 8'h59;
    localparam opcode_t IADD      = 8'h60;
    localparam opcode_t ISUB      = 8'h64;
    localparam opcode_t IMUL      = 8'h68;
    localparam opcode_t ISHL      = 8'h78;
    localparam opcode_t ISHR      = 8'h7a;
    localparam opcode_t IAND      = 8'h7e;
    localparam opcode_t IOR       = 8'h80;
    localparam opcode_t IXOR      = 8'h82;
    localparam opcode_t IFEQ      = 8'h99;    // compare top of stack with zero
    localparam opcode_t IFNE      = 8'h9a;
    localparam opcode_t IFLT      = 8'h9b;
    localparam opcode_t IFGE      = 8'h9c;
    localparam opcode_t IFGT      = 8'h9d;
    localparam opcode_t IFLE      = 8'h9e;
    localparam opcode_t IF_ICMPEQ = 8'h9f;    // compare the two top values
    localparam opcode_t IF_ICMPNE = 8'ha0;
    localparam opcode_t IF_ICMPLT = 8'ha1;
    localparam opcode_t IF_ICMPGE = 8'ha2;
    localparam opcode_t IF_ICMPGT = 8'ha3;
    localparam opcode_t IF_ICMPLE = 8'ha4;
    localparam opcode_t GOTO      = 8'ha7;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_MUL = 4'd2;       // low word only
    localparam alu_op_t ALU_AND = 4'd3;
    localparam alu_op_t ALU_OR  = 4'd4;
    localparam alu_op_t ALU_XOR = 4'd5;
    localparam alu_op_t ALU_SHL = 4'd6;
    localparam alu_op_t ALU_SHR = 4'd7;       // arithmetic

    localparam cmp_kind_t CMP_EQ = 3'd0;
    localparam cmp_kind_t CMP_NE = 3'd1;
    localparam cmp_kind_t CMP_LT = 3'd2;
    localparam cmp_kind_t CMP_GE = 3'd3;
    localparam cmp_kind_t CMP_GT = 3'd4;
    localparam cmp_kind_t CMP_LE = 3'd5;

endpackage

`default_nettype wire

//--- compile.f
common/jvm_isa_pkg.sv
common/jvm_core_pkg.sv
hw/bytecode_decoder.sv
hw/int_alu.sv
hw/control/exec_sequencer.sv
hw/control/branch_unit.sv
hw/jvm_control.sv
testbench/clock_gen.sv
testbench/tb_jvm_control.sv

//--- hw/bytecode_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module bytecode_decoder (
    input  jvm_isa_pkg::opcode_t   op_code,
    output jvm_core_pkg::decoded_t decoded
);
    import jvm_isa_pkg::*;
    import jvm_core_pkg::*;

    always_comb begin
        decoded = '0;                          // unknown opcodes do nothing
        decoded.is_alu  = op_code inside {IADD, ISUB, IMUL, IAND, IOR, IXOR, ISHL, ISHR};
        decoded.is_cmp  = op_code inside {IFEQ, IFNE, IFLT, IFGE, IFGT, IFLE};
        decoded.is_cmp2 = op_code inside {IF_ICMPEQ, IF_ICMPNE, IF_ICMPLT,
                                          IF_ICMPGE, IF_ICMPGT, IF_ICMPLE};
        decoded.is_goto = (op_code == GOTO);
        decoded.is_pop  = (op_code == POP);
        decoded.is_dup  = (op_code == DUP);

        case (op_code)
            ICONST_M1, ICONST_0, ICONST_1, ICONST_2, ICONST_3, ICONST_4, ICONST_5: begin
                decoded.is_const  = 1'b1;
                decoded.const_val = word_t'(op_code) - word_t'(ICONST_0);  // m1 wraps to -1
            end
            BIPUSH: begin
                decoded.is_lit    = 1'b1;
                decoded.arg_count = 2'd1;
            end
            SIPUSH: begin
                decoded.is_lit    = 1'b1;
                decoded.arg_count = 2'd2;
            end
            ILOAD: begin
                decoded.is_load       = 1'b1;
                decoded.has_index_arg = 1'b1;
            end
            ILOAD_0, ILOAD_1, ILOAD_2, ILOAD_3: begin
                decoded.is_load     = 1'b1;
                decoded.short_index = op_code - ILOAD_0;
            end
            ISTORE: begin
                decoded.is_store      = 1'b1;
                decoded.has_index_arg = 1'b1;
            end
            ISTORE_0, ISTORE_1, ISTORE_2, ISTORE_3: begin
                decoded.is_store    = 1'b1;
                decoded.short_index = op_code - ISTORE_0;
            end
            IADD: decoded.alu_op = ALU_ADD;
            ISUB: decoded.alu_op = ALU_SUB;
            IMUL: decoded.alu_op = ALU_MUL;
            IAND: decoded.alu_op = ALU_AND;
            IOR:  decoded.alu_op = ALU_OR;
            IXOR: decoded.alu_op = ALU_XOR;
            ISHL: decoded.alu_op = ALU_SHL;
            ISHR: decoded.alu_op = ALU_SHR;
            IFEQ, IF_ICMPEQ: decoded.cmp_kind = CMP_EQ;
            IFNE, IF_ICMPNE: decoded.cmp_kind = CMP_NE;
            IFLT, IF_ICMPLT: decoded.cmp_kind = CMP_LT;
            IFGE, IF_ICMPGE: decoded.cmp_kind = CMP_GE;
            IFGT, IF_ICMPGT: decoded.cmp_kind = CMP_GT;
            IFLE, IF_ICMPLE: decoded.cmp_kind = CMP_LE;
            default: begin
            end
        endcase

        if (decoded.has_index_arg) begin
            decoded.arg_count = 2'd1;
        end
        if (decoded.is_cmp || decoded.is_cmp2 || decoded.is_goto) begin
            decoded.arg_count = 2'd2;          // branch offset bytes
        end

        if (decoded.is_alu || decoded.is_cmp2) begin
            decoded.pops = 2'd2;
        end else if (decoded.is_cmp || decoded.is_store || decoded.is_pop || decoded.is_dup) begin
            decoded.pops = 2'd1;
        end

        if (decoded.is_dup) begin
            decoded.pushes = 2'd2;             // popped value goes back twice
        end else if (decoded.is_const || decoded.is_lit || decoded.is_alu || decoded.is_load) begin
            decoded.pushes = 2'd1;
        end
    end

endmodule

`default_nettype wire

//--- hw/control/branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     resolve,
    input  jvm_core_pkg::decoded_t   decoded,
    input  jvm_core_pkg::word_t      operand_a,
    input  jvm_core_pkg::word_t      operand_b,
    input  logic [7:0]               arg1,
    input  logic [7:0]               arg2,
    output jvm_core_pkg::pc_offset_t offset
);
    import jvm_isa_pkg::*;
    import jvm_core_pkg::*;

    logic signed [31:0] lhs;
    logic signed [31:0] rhs;
    logic               cond;
    logic               taken;

    assign lhs = signed'(operand_a);
    assign rhs = decoded.is_cmp2 ? signed'(operand_b) : 32'sd0;  // ifxx compares with zero

    always_comb begin
        case (decoded.cmp_kind)
            CMP_EQ:  cond = (lhs == rhs);
            CMP_NE:  cond = (lhs != rhs);
            CMP_LT:  cond = (lhs < rhs);
            CMP_GE:  cond = (lhs >= rhs);
            CMP_GT:  cond = (lhs > rhs);
            CMP_LE:  cond = (lhs <= rhs);
            default: cond = 1'b0;
        endcase
    end

    assign taken = decoded.is_goto || ((decoded.is_cmp || decoded.is_cmp2) && cond);

    always_ff @(posedge clk) begin
        if (reset) begin
            offset <= pc_offset_t'(1);
        end else if (resolve) begin
            offset <= taken ? pc_offset_t'({arg1, arg2})
                            : pc_offset_t'(decoded.arg_count) + pc_offset_t'(1);  // skip args
        end
    end

endmodule

`default_nettype wire

//--- hw/control/exec_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module exec_sequencer (
    input  logic                     clk,
    input  logic                     reset,
    input  jvm_isa_pkg::opcode_t     op_code,
    input  logic [7:0]               arg1,
    input  logic [7:0]               arg2,
    input  jvm_core_pkg::decoded_t   decoded,
    input  jvm_core_pkg::word_t      alu_result,
    output jvm_core_pkg::word_t      operand_a,
    output jvm_core_pkg::word_t      operand_b,
    output logic                     resolve,
    output jvm_core_pkg::stack_req_t stack_req,
    input  jvm_core_pkg::stack_rsp_t stack_rsp,
    output jvm_core_pkg::lva_req_t   lva_req,
    input  jvm_core_pkg::lva_rsp_t   lva_rsp,
    output logic                     op_done
);
    import jvm_isa_pkg::*;
    import jvm_core_pkg::*;

    seq_state_t state;
    logic [1:0] wait_cnt;       // fetch wait after done
    logic [1:0] pops_left;
    logic [1:0] pushes_left;
    word_t      lva_data;       // value from a local load
    word_t      push_value;
    logic       active;

    // invoke and return codes decode to no class, so they idle like nop
    assign active = (op_code != NOP) &&
                    (decoded.pops != 2'd0 || decoded.pushes != 2'd0 || decoded.is_goto);

    assign resolve = (state == ST_EXEC);    // branch unit registers offset here

    always_comb begin
        if (decoded.is_const) begin
            push_value = decoded.const_val;
        end else if (decoded.is_lit && decoded.arg_count == 2'd2) begin
            push_value = {{16{arg1[7]}}, arg1, arg2};
        end else if (decoded.is_lit) begin
            push_value = {{24{arg1[7]}}, arg1};
        end else if (decoded.is_alu) begin
            push_value = alu_result;
        end else if (decoded.is_load) begin
            push_value = lva_data;
        end else begin
            push_value = operand_a;         // dup
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= ST_IDLE;
            wait_cnt          <= 2'(FETCH_WAIT);
            pops_left         <= 2'd0;
            pushes_left       <= 2'd0;
            stack_req.trigger <= 1'b0;
            lva_req.trigger   <= 1'b0;
            op_done           <= 1'b0;
        end else begin
            stack_req.trigger <= 1'b0;      // all strobes last one cycle
            lva_req.trigger   <= 1'b0;
            op_done           <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wait_cnt != 2'd0) begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end else if (active) begin
                        pops_left   <= decoded.pops;
                        pushes_left <= decoded.pushes;
                        if (decoded.pops != 2'd0) begin
                            stack_req.push    <= 1'b0;
                            stack_req.trigger <= 1'b1;
                            state             <= ST_POP_LOAD;
                        end else if (decoded.is_load) begin
                            state <= ST_LVA_START;
                        end else begin
                            state <= ST_EXEC;
                        end
                    end
                end
                ST_POP_LOAD: begin
                    if (stack_rsp.done) begin
                        operand_a <= stack_rsp.rdata;   // newest pop is the deeper value
                        operand_b <= operand_a;
                        if (pops_left == 2'd1) begin
                            state <= decoded.is_store ? ST_LVA_START : ST_EXEC;
                        end else begin
                            pops_left         <= pops_left - 2'd1;
                            stack_req.push    <= 1'b0;
                            stack_req.trigger <= 1'b1;
                        end
                    end
                end
                ST_LVA_START: begin
                    lva_req.trigger <= 1'b1;
                    lva_req.write   <= decoded.is_store;
                    lva_req.index   <= decoded.has_index_arg ? arg1 : decoded.short_index;
                    lva_req.wdata   <= operand_a;
                    state           <= ST_LVA_WAIT;
                end
                ST_LVA_WAIT: begin
                    if (lva_rsp.done) begin
                        lva_data <= lva_rsp.rdata;
                        state    <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    stack_req.wdata <= push_value;
                    if (pushes_left != 2'd0) begin
                        state <= ST_PUSH;
                    end else begin
                        op_done  <= 1'b1;
                        wait_cnt <= 2'(FETCH_WAIT);
                        state    <= ST_IDLE;
                    end
                end
                ST_PUSH: begin
                    stack_req.push    <= 1'b1;
                    stack_req.trigger <= 1'b1;
                    state             <= ST_PUSH_WAIT;
                end
                ST_PUSH_WAIT: begin
                    if (stack_rsp.done) begin
                        if (pushes_left == 2'd1) begin
                            op_done  <= 1'b1;
                            wait_cnt <= 2'(FETCH_WAIT);
                            state    <= ST_IDLE;
                        end else begin
                            pushes_left <= pushes_left - 2'd1;  // second copy of dup
                            state       <= ST_PUSH;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    input  jvm_core_pkg::word_t   operand_a,   // deeper stack value
    input  jvm_core_pkg::word_t   operand_b,   // top of stack
    input  jvm_isa_pkg::alu_op_t  op_select,
    output jvm_core_pkg::word_t   result
);
    import jvm_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = operand_b[4:0];

    always_comb begin
        case (op_select)
            ALU_ADD: result = operand_a + operand_b;
            ALU_SUB: result = operand_a - operand_b;
            ALU_MUL: result = operand_a * operand_b;       // low 32 bits
            ALU_AND: result = operand_a & operand_b;
            ALU_OR:  result = operand_a | operand_b;
            ALU_XOR: result = operand_a ^ operand_b;
            ALU_SHL: result = operand_a << shamt;
            ALU_SHR: result = $signed(operand_a) >>> shamt;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/jvm_control.sv
`timescale 1ns/10ps
`default_nettype none

module jvm_control (
    input  logic                     clk,
    input  logic                     reset,
    input  jvm_isa_pkg::opcode_t     op_code,   // held stable until op_done
    input  logic [7:0]               arg1,
    input  logic [7:0]               arg2,
    input  jvm_core_pkg::stack_rsp_t stack_rsp,
    input  jvm_core_pkg::lva_rsp_t   lva_rsp,
    output jvm_core_pkg::stack_req_t stack_req,
    output jvm_core_pkg::lva_req_t   lva_req,
    output logic                     op_done,
    output jvm_core_pkg::pc_offset_t offset     // valid with op_done
);
    import jvm_core_pkg::*;

    decoded_t decoded;
    word_t    operand_a;
    word_t    operand_b;
    word_t    alu_result;
    logic     resolve;

    bytecode_decoder u_bytecode_decoder (
        .op_code (op_code),
        .decoded (decoded)
    );

    int_alu u_int_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op_select (decoded.alu_op),
        .result    (alu_result)
    );

    exec_sequencer u_exec_sequencer (
        .clk        (clk),
        .reset      (reset),
        .op_code    (op_code),
        .arg1       (arg1),
        .arg2       (arg2),
        .decoded    (decoded),
        .alu_result (alu_result),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .resolve    (resolve),
        .stack_req  (stack_req),
        .stack_rsp  (stack_rsp),
        .lva_req    (lva_req),
        .lva_rsp    (lva_rsp),
        .op_done    (op_done)
    );

    branch_unit u_branch_unit (
        .clk       (clk),
        .reset     (reset),
        .resolve   (resolve),
        .decoded   (decoded),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .arg1      (arg1),
        .arg2      (arg2),
        .offset    (offset)
    );

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD = 5;   // 10 ns clock
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;                 // released just after an edge
    end

endmodule

`default_nettype wire

//--- testbench/tb_jvm_control.sv
`timescale 1ns/10ps
`default_nettype none

module tb_jvm_control;
    import jvm_isa_pkg::*;
    import jvm_core_pkg::*;

    localparam int N_INSTR    = 200;
    localparam int CLK_PERIOD = 10;
    localparam int MAX_DEPTH  = 16;    // model stack limit
    localparam int STACK_SIZE = 32;    // responder stack size

    logic       clk;
    logic       reset;
    opcode_t    op_code;
    logic [7:0] arg1;
    logic [7:0] arg2;
    stack_req_t stack_req;
    stack_rsp_t stack_rsp;
    lva_req_t   lva_req;
    lva_rsp_t   lva_rsp;
    logic       op_done;
    pc_offset_t offset;

    int seed         = 54;
    int value_errors = 0;
    int other_errors = 0;
    int instr_num    = 0;

    word_t stack_mem [0:STACK_SIZE-1];  // responder side
    int    stack_depth;
    word_t lva_mem [0:255];
    word_t model_stack [0:MAX_DEPTH-1]; // reference model side
    int    model_depth;
    word_t model_locals [0:255];

    clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    jvm_control u_jvm_control (
        .clk       (clk),
        .reset     (reset),
        .op_code   (op_code),
        .arg1      (arg1),
        .arg2      (arg2),
        .stack_rsp (stack_rsp),
        .lva_rsp   (lva_rsp),
        .stack_req (stack_req),
        .lva_req   (lva_req),
        .op_done   (op_done),
        .offset    (offset)
    );

    function automatic word_t local_fill(input int idx);
        local_fill = 32'h9e37_79b9 * word_t'(idx + 1);  // distinct per index
    endfunction

    function automatic bit is_alu_op(input opcode_t op);
        is_alu_op = (op == IADD) || (op == ISUB) || (op == IMUL) || (op == IAND) ||
                    (op == IOR) || (op == IXOR) || (op == ISHL) || (op == ISHR);
    endfunction

    // stack effect of each kept opcode
    // known stays low for anything else
    task automatic op_shape(input opcode_t op, output bit known, output int pops,
                            output int pushes);
        known  = 1'b1;
        pops   = 0;
        pushes = 0;
        if ((op >= ICONST_M1 && op <= ICONST_5) || op == BIPUSH || op == SIPUSH ||
            op == ILOAD || (op >= ILOAD_0 && op <= ILOAD_3)) begin
            pushes = 1;
        end else if (op == ISTORE || (op >= ISTORE_0 && op <= ISTORE_3) || op == POP ||
                     (op >= IFEQ && op <= IFLE)) begin
            pops = 1;
        end else if (op == DUP) begin
            pops   = 1;
            pushes = 2;
        end else if (is_alu_op(op)) begin
            pops   = 2;
            pushes = 1;
        end else if (op >= IF_ICMPEQ && op <= IF_ICMPLE) begin
            pops = 2;
        end else if (op != GOTO) begin
            known = 1'b0;
        end
    endtask

    function automatic string op_class(input opcode_t op);
        if (op >= ICONST_M1 && op <= ICONST_5)
            op_class = "iconst";
        else if (op == BIPUSH || op == SIPUSH)
            op_class = "literal";
        else if (is_alu_op(op))
            op_class = "alu";
        else if (op >= IFEQ && op <= IFLE)
            op_class = "ifxx";
        else if (op >= IF_ICMPEQ && op <= IF_ICMPLE)
            op_class = "if_icmp";
        else if (op == GOTO)
            op_class = "goto";
        else if (op == ILOAD || (op >= ILOAD_0 && op <= ILOAD_3))
            op_class = "iload";
        else if (op == ISTORE || (op >= ISTORE_0 && op <= ISTORE_3))
            op_class = "istore";
        else
            op_class = (op == DUP) ? "dup" : "pop";
    endfunction

    // a is the deeper value, b the top of stack
    function automatic word_t alu_model(input opcode_t op, input word_t a, input word_t b);
        case (op)
            IADD:    alu_model = a + b;
            ISUB:    alu_model = a - b;
            IMUL:    alu_model = a * b;
            IAND:    alu_model = a & b;
            IOR:     alu_model = a | b;
            IXOR:    alu_model = a ^ b;
            ISHL:    alu_model = a << b[4:0];
            ISHR:    alu_model = $signed(a) >>> b[4:0];
            default: alu_model = 'x;
        endcase
    endfunction

    // kind follows the JVM order eq, ne, lt, ge, gt, le
    function automatic bit cond_model(input int kind, input int lhs, input int rhs);
        case (kind)
            0:       cond_model = (lhs == rhs);
            1:       cond_model = (lhs != rhs);
            2:       cond_model = (lhs < rhs);
            3:       cond_model = (lhs >= rhs);
            4:       cond_model = (lhs > rhs);
            default: cond_model = (lhs <= rhs);
        endcase
    endfunction

    task automatic push_model(input word_t value);
        model_stack[model_depth] = value;
        model_depth++;
    endtask

    task automatic model_step(input opcode_t op, input logic [7:0] a1, input logic [7:0] a2,
                              input int pops, output pc_offset_t exp_offset);
        word_t top;
        word_t deep;
        int    args;
        int    lit;
        bit    taken;
        top   = (model_depth > 0) ? model_stack[model_depth - 1] : '0;
        deep  = (model_depth > 1) ? model_stack[model_depth - 2] : '0;
        model_depth -= pops;
        taken = 1'b0;
        args  = 0;
        if (op >= ICONST_M1 && op <= ICONST_5) begin
            push_model(word_t'(int'(op) - int'(ICONST_0)));
        end else if (op == BIPUSH) begin
            args = 1;
            lit  = int'(a1);
            if (lit > 127) begin
                lit -= 256;
            end
            push_model(word_t'(lit));
        end else if (op == SIPUSH) begin
            args = 2;
            lit  = int'({a1, a2});
            if (lit > 32767) begin
                lit -= 65536;
            end
            push_model(word_t'(lit));
        end else if (is_alu_op(op)) begin
            push_model(alu_model(op, deep, top));
        end else if (op >= IFEQ && op <= IFLE) begin
            args  = 2;
            taken = cond_model(int'(op - IFEQ), int'(top), 0);
        end else if (op >= IF_ICMPEQ && op <= IF_ICMPLE) begin
            args  = 2;
            taken = cond_model(int'(op - IF_ICMPEQ), int'(deep), int'(top));
        end else if (op == GOTO) begin
            args  = 2;
            taken = 1'b1;
        end else if (op == ILOAD) begin
            args = 1;
            push_model(model_locals[a1]);
        end else if (op >= ILOAD_0 && op <= ILOAD_3) begin
            push_model(model_locals[op - ILOAD_0]);
        end else if (op == ISTORE) begin
            args = 1;
            model_locals[a1] = top;
        end else if (op >= ISTORE_0 && op <= ISTORE_3) begin
            model_locals[op - ISTORE_0] = top;
        end else if (op == DUP) begin
            push_model(top);
            push_model(top);
        end
        exp_offset = taken ? pc_offset_t'({a1, a2}) : pc_offset_t'(args + 1);
    endtask

    task automatic check_result(input string name, input pc_offset_t exp_offset);
        int i;
        assert (offset == exp_offset) else begin
            value_errors++;
            $display("Fail %s offset: expected %0d, actual %0d", name, exp_offset, offset);
        end
        assert (stack_depth == model_depth) else begin
            value_errors++;
            $display("Fail %s depth: expected %0d, actual %0d", name, model_depth, stack_depth);
        end
        for (i = 0; i < model_depth && i < stack_depth; i++) begin
            assert (stack_mem[i] === model_stack[i]) else begin
                value_errors++;
                $display("Fail %s stack[%0d]: expected %h, actual %h",
                         name, i, model_stack[i], stack_mem[i]);
            end
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    endtask

    initial begin : stack_responder
        int    delay;
        logic  push;
        word_t wdata;
        stack_rsp   = '0;
        stack_depth = 0;
        forever begin
            @(posedge clk);
            #1;
            stack_rsp.done = 1'b0;              // done lasts one cycle
            if (stack_req.trigger) begin
                push  = stack_req.push;
                wdata = stack_req.wdata;
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                #1;
                if (push && stack_depth >= STACK_SIZE) begin
                    other_errors++;
                    $display("stack responder: push onto a full stack");
                end else if (push) begin
                    stack_mem[stack_depth] = wdata;
                    stack_depth++;
                end else if (stack_depth == 0) begin
                    other_errors++;
                    $display("stack responder: pop from an empty stack");
                    stack_rsp.rdata = 'x;
                end else begin
                    stack_depth--;
                    stack_rsp.rdata = stack_mem[stack_depth];
                end
                stack_rsp.done = 1'b1;
            end
        end
    end

    initial begin : lva_responder
        int       delay;
        logic     write;
        lva_index_t index;
        word_t    wdata;
        int       i;
        lva_rsp = '0;
        for (i = 0; i < 256; i++) begin
            lva_mem[i] = local_fill(i);
        end
        forever begin
            @(posedge clk);
            #1;
            lva_rsp.done = 1'b0;
            if (lva_req.trigger) begin
                write = lva_req.write;
                index = lva_req.index;
                wdata = lva_req.wdata;
                delay = 1 + int'($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                #1;
                if (write) begin
                    lva_mem[index] = wdata;
                end
                lva_rsp.rdata = lva_mem[index];
                lva_rsp.done  = 1'b1;
            end
        end
    end

    initial begin : program_driver
        opcode_t    op;
        logic [7:0] a1;
        logic [7:0] a2;
        bit         legal;
        int         pops;
        int         pushes;
        int         i;
        pc_offset_t exp_offset;
        string      name;
        op_code     = NOP;
        arg1        = '0;
        arg2        = '0;
        model_depth = 0;
        for (i = 0; i < 256; i++) begin
            model_locals[i] = local_fill(i);
        end
        wait (reset === 1'b0);

        // a held nop must leave both buses quiet
        repeat (8) begin
            @(posedge clk);
            #1;
            assert (!op_done && !stack_req.trigger && !lva_req.trigger) else begin
                other_errors++;
                $display("nop caused bus activity or an op_done pulse");
            end
        end

        for (instr_num = 0; instr_num < N_INSTR; instr_num++) begin
            legal = 1'b0;
            while (!legal) begin
                op = 8'($unsigned($random(seed)) % 168);
                op_shape(op, legal, pops, pushes);
                if (pops > model_depth || model_depth - pops + pushes > MAX_DEPTH) begin
                    legal = 1'b0;               // keep the stack within bounds
                end
            end
            a1 = 8'($random(seed));
            a2 = 8'($random(seed));
            if (op == ILOAD || op == ISTORE) begin
                a1 = a1 & 8'h07;                // small index range so loads hit stores
            end
            op_code = op;
            arg1    = a1;
            arg2    = a2;
            name    = $sformatf("%s #%0d", op_class(op), instr_num);
            model_step(op, a1, a2, pops, exp_offset);
            @(posedge clk);
            #1;
            while (!op_done) begin
                @(posedge clk);
                #1;
            end
            check_result(name, exp_offset);
        end

        report_counts();
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(N_INSTR * 60 * CLK_PERIOD);
        other_errors++;
        $display("timeout: instruction %0d never reached op_done", instr_num);
        report_counts();
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire
